//--- Bender.yml
package:
  name: intra_recon

sources:
  - intra_pkg.sv
  - intra_pred_4x4.sv
  - pred_queue.sv
  - recon_clip.sv
  - intra_recon_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_intra_recon_top.sv

//--- files.f
+incdir+.
intra_pkg.sv
intra_pred_4x4.sv
pred_queue.sv
recon_clip.sv
intra_recon_top.sv
tb_intra_recon_top.sv

//--- intra_pkg.sv
package intra_pkg;

    localparam int QUEUE_DEPTH = 4;                         // predicted blocks held
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [QUEUE_PTR_W-1:0] qptr_t;
    typedef logic [QUEUE_CNT_W-1:0] qcnt_t;

    typedef logic [7:0] pixel_t;

    // top row a..h (h top-right), left column i..l, corner m
    typedef struct packed {
        pixel_t a;
        pixel_t b;
        pixel_t c;
        pixel_t d;
        pixel_t e;
        pixel_t f;
        pixel_t g;
        pixel_t h;
        pixel_t i;
        pixel_t j;
        pixel_t k;
        pixel_t l;
        pixel_t m;
    } nbr_t;

    typedef enum logic [3:0] {
        MODE_VERTICAL        = 4'd0,
        MODE_HORIZONTAL      = 4'd1,
        MODE_DC              = 4'd2,
        MODE_DIAG_DOWN_LEFT  = 4'd3,
        MODE_DIAG_DOWN_RIGHT = 4'd4,
        MODE_VERT_RIGHT      = 4'd5,
        MODE_HORZ_DOWN       = 4'd6,
        MODE_VERT_LEFT       = 4'd7,
        MODE_HORZ_UP         = 4'd8   // 9..15 illegal
    } intra_mode_e;

    typedef struct packed {
        intra_mode_e mode;
        nbr_t        nbr;
    } pred_req_t;

    // raster order, index = row*4 + column
    typedef pixel_t [15:0] blk_t;

    typedef logic signed [8:0] res_sample_t;
    typedef res_sample_t [15:0] residue_t;

endpackage

//--- intra_pred_4x4.sv
module intra_pred_4x4 (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_strobe,
    input  intra_pkg::pred_req_t req,
    output logic                 pred_valid,
    output intra_pkg::blk_t      pred
);

    // neighbours laid out along the edge, l l k j i m a b c d e f g h h
    // nb[5] is the corner, left[s] = nb[4 - s], top[t] = nb[6 + t]
    intra_pkg::pixel_t nb [15];
    intra_pkg::blk_t   pred_next;
    logic [10:0]       dc_sum;
    intra_pkg::pixel_t dc_val;

    function automatic intra_pkg::pixel_t avg2(intra_pkg::pixel_t p, intra_pkg::pixel_t q);
        logic [8:0] s;
        s = {1'b0, p} + {1'b0, q} + 9'd1;
        return s[8:1];
    endfunction

    function automatic intra_pkg::pixel_t avg3(intra_pkg::pixel_t p, intra_pkg::pixel_t q,
                                               intra_pkg::pixel_t r);
        logic [9:0] s;
        s = {2'b00, p} + {1'b0, q, 1'b0} + {2'b00, r} + 10'd2;
        return s[9:2];
    endfunction

    always_comb begin
        nb[0]  = req.nbr.l;   // repeat of l for horizontal-up
        nb[1]  = req.nbr.l;
        nb[2]  = req.nbr.k;
        nb[3]  = req.nbr.j;
        nb[4]  = req.nbr.i;
        nb[5]  = req.nbr.m;
        nb[6]  = req.nbr.a;
        nb[7]  = req.nbr.b;
        nb[8]  = req.nbr.c;
        nb[9]  = req.nbr.d;
        nb[10] = req.nbr.e;
        nb[11] = req.nbr.f;
        nb[12] = req.nbr.g;
        nb[13] = req.nbr.h;
        nb[14] = req.nbr.h;   // repeat of h for diagonal down-left
    end

    assign dc_sum = 11'(req.nbr.a) + 11'(req.nbr.b) + 11'(req.nbr.c) + 11'(req.nbr.d)
                  + 11'(req.nbr.i) + 11'(req.nbr.j) + 11'(req.nbr.k) + 11'(req.nbr.l)
                  + 11'd4;
    assign dc_val = dc_sum[10:3];

    always_comb begin
        int z;
        int h;
        z = 0;
        h = 0;
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                case (req.mode)
                    intra_pkg::MODE_VERTICAL: begin
                        pred_next[y*4 + x] = nb[6 + x];
                    end
                    intra_pkg::MODE_HORIZONTAL: begin
                        pred_next[y*4 + x] = nb[4 - y];
                    end
                    intra_pkg::MODE_DIAG_DOWN_LEFT: begin
                        pred_next[y*4 + x] = avg3(nb[6 + x + y], nb[7 + x + y], nb[8 + x + y]);
                    end
                    intra_pkg::MODE_DIAG_DOWN_RIGHT: begin
                        h = 5 + x - y;   // centre tap on the edge
                        pred_next[y*4 + x] = avg3(nb[h - 1], nb[h], nb[h + 1]);
                    end
                    intra_pkg::MODE_VERT_RIGHT: begin
                        z = 2*x - y;
                        h = y >> 1;
                        if (z < -1)
                            pred_next[y*4 + x] = avg3(nb[5 - y], nb[6 - y], nb[7 - y]);
                        else if (z[0])
                            pred_next[y*4 + x] = avg3(nb[4 + x - h], nb[5 + x - h],
                                                      nb[6 + x - h]);
                        else
                            pred_next[y*4 + x] = avg2(nb[5 + x - h], nb[6 + x - h]);
                    end
                    intra_pkg::MODE_HORZ_DOWN: begin
                        z = 2*y - x;
                        h = y - (x >> 1);
                        if (z < -1)
                            pred_next[y*4 + x] = avg3(nb[5 + x], nb[4 + x], nb[3 + x]);
                        else if (z[0])
                            pred_next[y*4 + x] = avg3(nb[6 - h], nb[5 - h], nb[4 - h]);
                        else
                            pred_next[y*4 + x] = avg2(nb[5 - h], nb[4 - h]);
                    end
                    intra_pkg::MODE_VERT_LEFT: begin
                        h = x + (y >> 1);
                        if (y[0])
                            pred_next[y*4 + x] = avg3(nb[6 + h], nb[7 + h], nb[8 + h]);
                        else
                            pred_next[y*4 + x] = avg2(nb[6 + h], nb[7 + h]);
                    end
                    intra_pkg::MODE_HORZ_UP: begin
                        z = x + 2*y;
                        h = (z > 5) ? 2 : y + (x >> 1);   // clamped, unused past z = 5
                        if (z > 5)
                            pred_next[y*4 + x] = nb[0];
                        else if (z[0])
                            pred_next[y*4 + x] = avg3(nb[4 - h], nb[3 - h], nb[2 - h]);
                        else
                            pred_next[y*4 + x] = avg2(nb[4 - h], nb[3 - h]);
                    end
                    default: begin
                        pred_next[y*4 + x] = dc_val;   // DC, also for illegal modes
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= req_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (req_strobe) begin
            pred <= pred_next;
        end
    end

    a_legal_mode: assert property (@(posedge clk) disable iff (!rst_n)
        req_strobe |-> req.mode <= intra_pkg::MODE_HORZ_UP)
        else $error("illegal intra mode %0d requested", req.mode);

endmodule

//--- intra_recon_top.sv
module intra_recon_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_strobe,
    input  intra_pkg::pred_req_t req,
    input  logic                 residue_strobe,
    input  intra_pkg::residue_t  residue,
    output logic                 recon_valid,
    output intra_pkg::blk_t      recon,
    output logic                 overflow_error,
    output logic                 order_error
);

    logic            pred_valid;
    intra_pkg::blk_t pred;
    intra_pkg::blk_t head;
    logic            head_taken;

    intra_pred_4x4 intra_pred_4x4_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_strobe (req_strobe),
        .req        (req),
        .pred_valid (pred_valid),
        .pred       (pred)
    );

    pred_queue pred_queue_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .pred_valid     (pred_valid),
        .pred           (pred),
        .residue_strobe (residue_strobe),   // residue data itself bypasses the queue
        .head           (head),
        .head_taken     (head_taken),
        .overflow_error (overflow_error),
        .order_error    (order_error)
    );

    recon_clip recon_clip_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .head_taken  (head_taken),
        .head        (head),
        .residue     (residue),
        .recon_valid (recon_valid),
        .recon       (recon)
    );

endmodule

//--- pred_queue.sv
module pred_queue (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pred_valid,
    input  intra_pkg::blk_t pred,
    input  logic            residue_strobe,
    output intra_pkg::blk_t head,
    output logic            head_taken,
    output logic            overflow_error,
    output logic            order_error
);

    intra_pkg::blk_t  mem [intra_pkg::QUEUE_DEPTH];
    intra_pkg::qptr_t wr_ptr;
    intra_pkg::qptr_t rd_ptr;
    intra_pkg::qcnt_t count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    function automatic intra_pkg::qptr_t ptr_inc(intra_pkg::qptr_t p);
        if (p == intra_pkg::qptr_t'(intra_pkg::QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full  = (count == intra_pkg::qcnt_t'(intra_pkg::QUEUE_DEPTH));
    assign empty = (count == '0);

    assign push = pred_valid && !full;
    assign pop  = residue_strobe && !empty;   // sees only blocks stored before this cycle

    assign head           = mem[rd_ptr];
    assign head_taken     = pop;
    assign overflow_error = pred_valid && full;   // block dropped
    assign order_error    = residue_strobe && empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pred;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= intra_pkg::qcnt_t'(intra_pkg::QUEUE_DEPTH))
        else $error("queue count %0d above depth", count);

    a_pop_xor_error: assert property (@(posedge clk) disable iff (!rst_n)
        !(head_taken && order_error))
        else $error("pop and order error in the same cycle");

endmodule

//--- recon_clip.sv
module recon_clip (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                head_taken,
    input  intra_pkg::blk_t     head,
    input  intra_pkg::residue_t residue,
    output logic                recon_valid,
    output intra_pkg::blk_t     recon
);

    intra_pkg::blk_t sum_blk;

    function automatic intra_pkg::pixel_t clip_add(intra_pkg::pixel_t p,
                                                   intra_pkg::res_sample_t r);
        logic signed [9:0] s;
        s = $signed({2'b00, p}) + $signed({r[8], r});   // -256..510
        if (s[9]) begin
            return '0;   // negative
        end
        if (s[8]) begin
            return '1;   // above 255
        end
        return s[7:0];
    endfunction

    always_comb begin
        for (int n = 0; n < 16; n++) begin
            sum_blk[n] = clip_add(head[n], residue[n]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            recon_valid <= 1'b0;
        end else begin
            recon_valid <= head_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (head_taken) begin
            recon <= sum_blk;
        end
    end

    // back-to-back output needs a pop on each of the two edges before
    a_valid_run: assert property (@(posedge clk) disable iff (!rst_n)
        recon_valid && $past(recon_valid) |-> $past(head_taken, 1) && $past(head_taken, 2))
        else $error("recon_valid held without a matching pop");

endmodule

//--- tb_intra_model.svh
`ifndef TB_INTRA_MODEL_SVH
`define TB_INTRA_MODEL_SVH

// sample at (x, y) around the block, the edge row and column sit at -1
function automatic int model_px(intra_pkg::nbr_t n, int x, int y);
    if (y < 0) begin
        case (x)
            -1: return n.m;
            0: return n.a;
            1: return n.b;
            2: return n.c;
            3: return n.d;
            4: return n.e;
            5: return n.f;
            6: return n.g;
            default: return n.h;
        endcase
    end
    case (y)
        0: return n.i;
        1: return n.j;
        2: return n.k;
        default: return n.l;
    endcase
endfunction

function automatic int model_top2(intra_pkg::nbr_t n, int t);
    return (model_px(n, t, -1) + model_px(n, t + 1, -1) + 1) >> 1;
endfunction

function automatic int model_top3(intra_pkg::nbr_t n, int t);
    return (model_px(n, t, -1) + 2 * model_px(n, t + 1, -1)
            + model_px(n, t + 2, -1) + 2) >> 2;
endfunction

function automatic int model_left2(intra_pkg::nbr_t n, int s);
    return (model_px(n, -1, s) + model_px(n, -1, s + 1) + 1) >> 1;
endfunction

function automatic int model_left3(intra_pkg::nbr_t n, int s);
    return (model_px(n, -1, s) + 2 * model_px(n, -1, s + 1)
            + model_px(n, -1, s + 2) + 2) >> 2;
endfunction

function automatic intra_pkg::blk_t model_predict(intra_pkg::pred_req_t req);
    intra_pkg::blk_t blk;
    intra_pkg::nbr_t n;
    int dc;
    int corner;
    int v;
    int z;
    n = req.nbr;
    dc = 4;
    for (int t = 0; t < 4; t++) begin
        dc += model_px(n, t, -1) + model_px(n, -1, t);
    end
    corner = (n.i + 2 * n.m + n.a + 2) >> 2;
    for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
            case (req.mode)
                intra_pkg::MODE_VERTICAL: v = model_px(n, x, -1);
                intra_pkg::MODE_HORIZONTAL: v = model_px(n, -1, y);
                intra_pkg::MODE_DIAG_DOWN_LEFT: begin
                    if (x == 3 && y == 3)
                        v = (n.g + 3 * n.h + 2) >> 2;
                    else
                        v = model_top3(n, x + y);
                end
                intra_pkg::MODE_DIAG_DOWN_RIGHT: begin
                    if (x > y)
                        v = model_top3(n, x - y - 2);
                    else if (x < y)
                        v = model_left3(n, y - x - 2);
                    else
                        v = corner;
                end
                intra_pkg::MODE_VERT_RIGHT: begin
                    z = 2 * x - y;
                    if (z >= 0 && z % 2 == 0)
                        v = model_top2(n, x - (y >> 1) - 1);
                    else if (z > 0)
                        v = model_top3(n, x - (y >> 1) - 2);
                    else if (z == -1)
                        v = corner;
                    else
                        v = model_left3(n, y - 3);
                end
                intra_pkg::MODE_HORZ_DOWN: begin
                    z = 2 * y - x;
                    if (z >= 0 && z % 2 == 0)
                        v = model_left2(n, y - (x >> 1) - 1);
                    else if (z > 0)
                        v = model_left3(n, y - (x >> 1) - 2);
                    else if (z == -1)
                        v = corner;
                    else
                        v = model_top3(n, x - 3);
                end
                intra_pkg::MODE_VERT_LEFT: begin
                    if (y % 2 == 0)
                        v = model_top2(n, x + (y >> 1));
                    else
                        v = model_top3(n, x + (y >> 1));
                end
                intra_pkg::MODE_HORZ_UP: begin
                    z = x + 2 * y;
                    if (z > 5)
                        v = n.l;
                    else if (z == 5)
                        v = (n.k + 3 * n.l + 2) >> 2;
                    else if (z % 2 == 0)
                        v = model_left2(n, y + (x >> 1));
                    else
                        v = model_left3(n, y + (x >> 1));
                end
                default: v = dc >> 3;   // DC and illegal modes
            endcase
            blk[y * 4 + x] = intra_pkg::pixel_t'(v);
        end
    end
    return blk;
endfunction

function automatic intra_pkg::blk_t model_recon(intra_pkg::blk_t pred,
                                                intra_pkg::residue_t res);
    intra_pkg::blk_t blk;
    int s;
    for (int k = 0; k < 16; k++) begin
        s = int'(pred[k]) + int'($signed(res[k]));
        if (s < 0)
            s = 0;
        else if (s > 255)
            s = 255;
        blk[k] = intra_pkg::pixel_t'(s);
    end
    return blk;
endfunction

`endif

//--- tb_intra_recon_top.sv
module tb_intra_recon_top;

    logic                 clk;
    logic                 rst_n;
    logic                 req_strobe;
    intra_pkg::pred_req_t req;
    logic                 residue_strobe;
    intra_pkg::residue_t  residue;
    logic                 recon_valid;
    intra_pkg::blk_t      recon;
    logic                 overflow_error;
    logic                 order_error;

    intra_pkg::blk_t exp_pred_q [$];    // predictions the queue should hold
    intra_pkg::blk_t exp_recon_q [$];   // reconstructions still to come out
    intra_pkg::blk_t pend_blk;
    logic            pend_valid = 1'b0;
    logic            exp_pop = 1'b0;
    logic            exp_order = 1'b0;
    logic            exp_overflow = 1'b0;
    logic            prev_pop = 1'b0;
    int              errors = 0;
    int              test_err_start = 0;
    int              passed = 0;
    int              failed = 0;
    int              recon_seen = 0;
    int              order_seen = 0;
    int              overflow_seen = 0;
    int              cycles = 0;

    `include "tb_intra_model.svh"

    intra_recon_top intra_recon_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_strobe     (req_strobe),
        .req            (req),
        .residue_strobe (residue_strobe),
        .residue        (residue),
        .recon_valid    (recon_valid),
        .recon          (recon),
        .overflow_error (overflow_error),
        .order_error    (order_error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic intra_pkg::nbr_t random_nbr(input bit extreme);
        logic [103:0] bits;
        for (int k = 0; k < 13; k++) begin
            if (extreme)
                bits[k*8 +: 8] = ($urandom & 1) ? 8'hff : 8'h00;
            else
                bits[k*8 +: 8] = 8'($urandom);
        end
        return intra_pkg::nbr_t'(bits);
    endfunction

    function automatic intra_pkg::residue_t random_residue(input bit extreme);
        intra_pkg::residue_t res;
        for (int k = 0; k < 16; k++) begin
            if (extreme)
                res[k] = ($urandom & 1) ? 9'sh0ff : 9'sh100;   // +255 or -256
            else
                res[k] = 9'($urandom);
        end
        return res;
    endfunction

    function automatic intra_pkg::intra_mode_e random_mode();
        return intra_pkg::intra_mode_e'(4'($urandom_range(0, 8)));
    endfunction

    // drives one cycle and steps the queue model with the DUT's timing
    task automatic drive_cycle(input logic do_req, input intra_pkg::pred_req_t r,
                               input logic do_res, input intra_pkg::residue_t rs);
        int size;
        intra_pkg::blk_t popped;
        @(negedge clk);
        req_strobe = do_req;
        req = r;
        residue_strobe = do_res;
        residue = rs;
        size = exp_pred_q.size();
        exp_overflow = pend_valid && (size == intra_pkg::QUEUE_DEPTH);
        exp_order = do_res && (size == 0);
        exp_pop = do_res && (size > 0);
        if (exp_pop) begin
            popped = exp_pred_q.pop_front();
            exp_recon_q.push_back(model_recon(popped, rs));
        end
        if (pend_valid && size < intra_pkg::QUEUE_DEPTH)
            exp_pred_q.push_back(pend_blk);   // full is judged before the pop
        pend_valid = do_req;
        pend_blk = model_predict(r);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0);
    endtask

    task automatic expect_count(input string what, input int got, input int want);
        if (got != want) begin
            $display("%s: saw %0d, expected %0d", what, got, want);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        idle(4);
        if (errors == test_err_start) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - test_err_start);
        end
        test_err_start = errors;
    endtask

    // samples late in the low phase, after inputs and before the next edge
    always begin : compare_proc
        intra_pkg::blk_t want;
        @(negedge clk);
        #2;
        if (recon_valid !== prev_pop) begin
            $display("MISMATCH recon_valid: got %h expected %h", recon_valid, prev_pop);
            errors++;
        end
        if (recon_valid === 1'b1) begin
            recon_seen++;
            if (exp_recon_q.size() == 0) begin
                $display("recon_valid came with no block expected");
                errors++;
            end else begin
                want = exp_recon_q.pop_front();
                if (recon !== want) begin
                    $display("MISMATCH recon: got %h expected %h", recon, want);
                    errors++;
                end
            end
        end
        if (order_error !== exp_order) begin
            $display("MISMATCH order_error: got %h expected %h", order_error, exp_order);
            errors++;
        end
        if (overflow_error !== exp_overflow) begin
            $display("MISMATCH overflow_error: got %h expected %h", overflow_error,
                     exp_overflow);
            errors++;
        end
        if (order_error === 1'b1)
            order_seen++;
        if (overflow_error === 1'b1)
            overflow_seen++;
        prev_pop = exp_pop;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin   // about four times the full run
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        intra_pkg::pred_req_t r;
        int seed;
        int gap;
        int base_recon;
        int base_order;
        int base_ovf;
        seed = $urandom(32'h6ca2);
        rst_n = 1'b0;
        req_strobe = 1'b0;
        req = '0;
        residue_strobe = 1'b0;
        residue = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        base_recon = recon_seen;
        base_order = order_seen;
        idle(2);
        drive_cycle(1'b0, '0, 1'b1, random_residue(1'b0));   // nothing queued yet
        idle(2);
        expect_count("order_error pulses", order_seen - base_order, 1);
        expect_count("recon blocks", recon_seen - base_recon, 0);
        finish_test("reset state");

        for (int md = 0; md < 9; md++) begin
            for (int k = 0; k < 20; k++) begin
                r.mode = intra_pkg::intra_mode_e'(md);
                r.nbr = random_nbr(1'b0);
                drive_cycle(1'b1, r, 1'b0, '0);
                gap = $urandom_range(1, 5);
                idle(gap);
                drive_cycle(1'b0, '0, 1'b1, random_residue(1'b0));
            end
            idle(2);
        end
        finish_test("every mode");

        r.mode = intra_pkg::MODE_DC;
        r.nbr = {13{8'hff}};
        drive_cycle(1'b1, r, 1'b0, '0);
        idle(1);
        drive_cycle(1'b0, '0, 1'b1, {16{9'sh0ff}});
        r.nbr = '0;
        drive_cycle(1'b1, r, 1'b0, '0);
        idle(1);
        drive_cycle(1'b0, '0, 1'b1, {16{9'sh100}});
        for (int k = 0; k < 12; k++) begin
            r.mode = random_mode();
            r.nbr = random_nbr(1'b1);
            drive_cycle(1'b1, r, 1'b0, '0);
            idle(1);
            drive_cycle(1'b0, '0, 1'b1, random_residue(1'b1));
        end
        finish_test("clipping");

        base_recon = recon_seen;
        for (int k = 0; k < 4; k++) begin
            r.mode = random_mode();
            r.nbr = random_nbr(1'b0);
            drive_cycle(1'b1, r, 1'b0, '0);
        end
        idle(1);   // last block lands, queue full
        for (int k = 0; k < 4; k++)
            drive_cycle(1'b0, '0, 1'b1, random_residue(1'b0));
        idle(2);
        expect_count("recon blocks", recon_seen - base_recon, 4);
        finish_test("queue depth and order");

        base_recon = recon_seen;
        base_ovf = overflow_seen;
        for (int k = 0; k < 5; k++) begin
            r.mode = random_mode();
            r.nbr = random_nbr(1'b0);
            drive_cycle(1'b1, r, 1'b0, '0);
            if (k == 3)
                idle(1);
        end
        idle(1);   // fifth block dropped here
        for (int k = 0; k < 4; k++)
            drive_cycle(1'b0, '0, 1'b1, random_residue(1'b0));
        idle(2);
        expect_count("overflow_error pulses", overflow_seen - base_ovf, 1);
        expect_count("recon blocks", recon_seen - base_recon, 4);
        finish_test("overflow");

        for (int k = 0; k < 2; k++) begin
            r.mode = random_mode();
            r.nbr = random_nbr(1'b0);
            drive_cycle(1'b1, r, 1'b0, '0);
        end
        for (int k = 0; k < 30; k++) begin
            r.mode = random_mode();
            r.nbr = random_nbr(1'b0);
            drive_cycle(1'b1, r, 1'b1, random_residue(1'b0));
        end
        while (exp_pred_q.size() > 0 || pend_valid) begin
            if (exp_pred_q.size() > 0)
                drive_cycle(1'b0, '0, 1'b1, random_residue(1'b0));
            else
                idle(1);
        end
        finish_test("simultaneous push and pop");

        if (exp_recon_q.size() != 0) begin
            $display("%0d expected blocks never came out", exp_recon_q.size());
            errors++;
        end
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
